// ==== hw/uart_line_pkg.sv ====
package uart_line_pkg;

  // one frame is start, 8 data, parity, stop
  localparam int data_bits  = 8;
  localparam int frame_bits = 11;

  typedef struct packed {
    logic [data_bits-1:0] data;
    logic                 parity_err; // parity bit disagrees with odd parity of data
    logic                 frame_err;  // stop bit sampled low
  } rx_frame_t;

  // odd parity bit that makes the total count of ones odd
  function automatic logic odd_parity(input logic [data_bits-1:0] d);
    odd_parity = ~^d;
  endfunction

endpackage

// ==== hw/uart_cmd_pkg.sv ====
package uart_cmd_pkg;

  localparam int addr_bits = 7;

  // command word as the host drives it
  // bit 15 write, bits 14:8 register address, bits 7:0 write data
  typedef struct packed {
    logic                 write;
    logic [addr_bits-1:0] addr;
    logic [7:0]           data;
  } cmd_t;

  // read response returned to the host
  typedef struct packed {
    logic [7:0] data;
    logic       parity_err;
    logic       frame_err;
    logic       timeout; // no reply start bit in time and data forced to zero
  } rsp_t;

  // first byte on the line for both reads and writes
  function automatic logic [7:0] header_byte(input cmd_t c);
    header_byte = {c.write, c.addr};
  endfunction

endpackage

// ==== hw/uart_tx_frame.sv ====
`timescale 1ns/1ps

module uart_tx_frame #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_req,
  input  logic [7:0] tx_byte,
  output logic       tx_ack,
  output logic       tx
);

  localparam int cnt_w = $clog2(CLKS_PER_BIT + 1);
  localparam int idx_w = $clog2(uart_line_pkg::frame_bits);

  typedef enum logic [1:0] {
    st_idle,
    st_send,
    st_done
  } state_t;

  state_t                               state;
  logic [cnt_w-1:0]                     clk_cnt;
  logic [idx_w-1:0]                     bit_idx;
  logic [uart_line_pkg::frame_bits-1:0] shift_q; // lsb drives the line
  logic                                 bit_end;

  assign bit_end = (clk_cnt == cnt_w'(CLKS_PER_BIT - 1));
  assign tx      = shift_q[0];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= st_idle;
      clk_cnt <= '0;
      bit_idx <= '0;
      shift_q <= '1; // line idles high
      tx_ack  <= 1'b0;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          if (tx_req)
          begin
            // stop, parity, data lsb first, start
            shift_q <= {1'b1, uart_line_pkg::odd_parity(tx_byte), tx_byte, 1'b0};
            clk_cnt <= '0;
            bit_idx <= '0;
            state   <= st_send;
          end
        end
        st_send:
        begin
          if (bit_end)
          begin
            clk_cnt <= '0;
            if (bit_idx == idx_w'(uart_line_pkg::frame_bits - 1))
            begin
              tx_ack <= 1'b1; // end of stop bit
              state  <= st_done;
            end
            else
            begin
              bit_idx <= bit_idx + 1'b1;
              shift_q <= {1'b1, shift_q[uart_line_pkg::frame_bits-1:1]};
            end
          end
          else
            clk_cnt <= clk_cnt + 1'b1;
        end
        st_done:
        begin
          if (!tx_req)
          begin
            tx_ack <= 1'b0;
            state  <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

// ==== hw/uart_rx_frame.sv ====
`timescale 1ns/1ps

module uart_rx_frame #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     rx,
  output logic                     rx_valid,
  output uart_line_pkg::rx_frame_t rx_frame
);

  localparam int cnt_w = $clog2(CLKS_PER_BIT + 1);
  localparam int idx_w = $clog2(uart_line_pkg::frame_bits);
  // data bits plus parity between start and stop
  localparam int body_bits = uart_line_pkg::frame_bits - 2;

  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_body,
    st_stop
  } state_t;

  state_t                 state;
  logic                   rx_meta;
  logic                   rx_sync;
  logic                   rx_prev;
  logic [cnt_w-1:0]       clk_cnt;
  logic [idx_w-1:0]       bit_idx;
  logic [body_bits-1:0]   shift_q; // parity ends up in the msb
  logic                   half_tick;
  logic                   bit_tick;

  assign half_tick = (clk_cnt == cnt_w'(CLKS_PER_BIT / 2 - 1));
  assign bit_tick  = (clk_cnt == cnt_w'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta  <= 1'b1;
      rx_sync  <= 1'b1;
      rx_prev  <= 1'b1;
      state    <= st_idle;
      clk_cnt  <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end
    else
    begin
      rx_meta  <= rx;
      rx_sync  <= rx_meta;
      rx_prev  <= rx_sync;
      rx_valid <= 1'b0;
      clk_cnt  <= clk_cnt + 1'b1;
      case (state)
        st_idle:
        begin
          clk_cnt <= '0;
          if (rx_prev && !rx_sync)
            state <= st_start; // falling edge that may be a start bit
        end
        st_start:
        begin
          if (half_tick)
          begin
            clk_cnt <= '0;
            bit_idx <= '0;
            state   <= rx_sync ? st_idle : st_body; // high at mid bit is a glitch
          end
        end
        st_body:
        begin
          if (bit_tick)
          begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == idx_w'(body_bits - 1))
              state <= st_stop;
          end
        end
        st_stop:
        begin
          if (bit_tick)
          begin
            rx_valid <= 1'b1;
            state    <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // payload path, sampled at mid bit
  always_ff @(posedge clk)
  begin
    if (state == st_body && bit_tick)
      shift_q <= {rx_sync, shift_q[body_bits-1:1]};
    if (state == st_stop && bit_tick)
    begin
      rx_frame.data       <= shift_q[body_bits-2:0];
      rx_frame.parity_err <= shift_q[body_bits-1] !=
                             uart_line_pkg::odd_parity(shift_q[body_bits-2:0]);
      rx_frame.frame_err  <= !rx_sync;
    end
  end

endmodule

// ==== hw/uart_cmd_ctrl.sv ====
`timescale 1ns/1ps

module uart_cmd_ctrl #(
  parameter int GAP_CLKS         = 100,
  parameter int RSP_TIMEOUT_CLKS = 20000
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     cmd_req,
  input  uart_cmd_pkg::cmd_t       cmd,
  output logic                     cmd_ack,
  output logic                     rsp_req,
  output uart_cmd_pkg::rsp_t       rsp,
  input  logic                     rsp_ack,
  output logic                     tx_req,
  output logic [7:0]               tx_byte,
  input  logic                     tx_ack,
  input  logic                     rx_valid,
  input  uart_line_pkg::rx_frame_t rx_frame
);

  localparam int tmr_max = (GAP_CLKS > RSP_TIMEOUT_CLKS) ? GAP_CLKS : RSP_TIMEOUT_CLKS;
  localparam int tmr_w   = $clog2(tmr_max + 1);

  typedef enum logic [2:0] {
    st_idle,
    st_hdr,
    st_gap,
    st_data,
    st_wait_rsp,
    st_rsp,
    st_rsp_rel,
    st_done
  } state_t;

  state_t             state;
  uart_cmd_pkg::cmd_t cmd_q;
  logic [tmr_w-1:0]   timer;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= st_idle;
      cmd_q   <= '0;
      timer   <= '0;
      cmd_ack <= 1'b0;
      rsp_req <= 1'b0;
      rsp     <= '0;
      tx_req  <= 1'b0;
      tx_byte <= '0;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          // previous transmit handshake must be fully closed
          if (cmd_req && !tx_ack)
          begin
            cmd_q   <= cmd;
            tx_byte <= uart_cmd_pkg::header_byte(cmd);
            tx_req  <= 1'b1;
            state   <= st_hdr;
          end
        end
        st_hdr:
        begin
          if (tx_ack)
          begin
            tx_req <= 1'b0;
            timer  <= '0; // gap and reply timeout both start here
            state  <= cmd_q.write ? st_gap : st_wait_rsp;
          end
        end
        st_gap:
        begin
          if (timer == tmr_w'(GAP_CLKS - 1) && !tx_ack)
          begin
            tx_byte <= cmd_q.data;
            tx_req  <= 1'b1;
            state   <= st_data;
          end
          else if (timer != tmr_w'(GAP_CLKS - 1))
            timer <= timer + 1'b1;
        end
        st_data:
        begin
          if (tx_ack)
          begin
            tx_req  <= 1'b0;
            cmd_ack <= 1'b1; // write has no response phase
            state   <= st_done;
          end
        end
        st_wait_rsp:
        begin
          if (rx_valid)
          begin
            rsp     <= '{data: rx_frame.data, parity_err: rx_frame.parity_err,
                         frame_err: rx_frame.frame_err, timeout: 1'b0};
            rsp_req <= 1'b1;
            state   <= st_rsp;
          end
          else if (timer == tmr_w'(RSP_TIMEOUT_CLKS - 1))
          begin
            rsp     <= '{data: 8'h00, parity_err: 1'b0, frame_err: 1'b0, timeout: 1'b1};
            rsp_req <= 1'b1;
            state   <= st_rsp; // a late reply frame is dropped
          end
          else
            timer <= timer + 1'b1;
        end
        st_rsp:
        begin
          if (rsp_ack)
          begin
            rsp_req <= 1'b0;
            state   <= st_rsp_rel;
          end
        end
        st_rsp_rel:
        begin
          if (!rsp_ack)
          begin
            cmd_ack <= 1'b1;
            state   <= st_done;
          end
        end
        st_done:
        begin
          if (!cmd_req)
          begin
            cmd_ack <= 1'b0;
            state   <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

// ==== hw/uart_cmd_bridge.sv ====
`timescale 1ns/1ps

module uart_cmd_bridge #(
  parameter int CLKS_PER_BIT     = 434,
  parameter int GAP_CLKS         = 100,
  parameter int RSP_TIMEOUT_CLKS = 20000
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               cmd_req,
  input  uart_cmd_pkg::cmd_t cmd,
  output logic               cmd_ack,
  output logic               rsp_req,
  output uart_cmd_pkg::rsp_t rsp,
  input  logic               rsp_ack,
  output logic               tx,
  input  logic               rx
);

  logic                     tx_req;
  logic [7:0]               tx_byte;
  logic                     tx_ack;
  logic                     rx_valid;
  uart_line_pkg::rx_frame_t rx_frame;

  uart_cmd_ctrl #(
    .GAP_CLKS         (GAP_CLKS),
    .RSP_TIMEOUT_CLKS (RSP_TIMEOUT_CLKS)
  ) uart_cmd_ctrl_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_req  (cmd_req),
    .cmd      (cmd),
    .cmd_ack  (cmd_ack),
    .rsp_req  (rsp_req),
    .rsp      (rsp),
    .rsp_ack  (rsp_ack),
    .tx_req   (tx_req),
    .tx_byte  (tx_byte),
    .tx_ack   (tx_ack),
    .rx_valid (rx_valid),
    .rx_frame (rx_frame)
  );

  uart_tx_frame #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) uart_tx_frame_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_req  (tx_req),
    .tx_byte (tx_byte),
    .tx_ack  (tx_ack),
    .tx      (tx)
  );

  uart_rx_frame #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) uart_rx_frame_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_valid (rx_valid),
    .rx_frame (rx_frame)
  );

endmodule

// ==== test/uart_peer_model.sv ====
`timescale 1ns/1ps

module uart_peer_model #(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx,             // bridge to peer
  output logic       rx,             // peer to bridge
  input  logic       corrupt_parity, // flip the parity bit of the next reply
  input  logic       silent,         // leave the next read unanswered
  input  int         reply_delay,
  output int         frame_cnt,
  output logic [7:0] frame_byte,
  output logic       parity_ok,
  output logic       stop_ok,
  output int         gap_clks        // high clocks on tx before this start bit
);

  logic [7:0] regs [128];
  logic [6:0] addr_q;
  logic       expect_data;
  int         idle_cnt;
  logic [7:0] rx_byte;
  logic       rx_par;
  logic       rx_stop;

  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk);
  endtask

  // entered on the first clock that sees the start bit low
  task automatic receive_frame(output logic [7:0] d, output logic p, output logic s);
    logic [8:0] body;
    wait_clks(CLKS_PER_BIT / 2);
    for (int i = 0; i < 9; i++)
    begin
      wait_clks(CLKS_PER_BIT);
      body[i] = tx;
    end
    wait_clks(CLKS_PER_BIT);
    s = tx;
    d = body[7:0];
    p = body[8];
  endtask

  task automatic send_frame(input logic [7:0] d, input logic bad_parity);
    logic [10:0] bits;
    bits = {1'b1, (~^d) ^ bad_parity, d, 1'b0};
    for (int i = 0; i < 11; i++)
    begin
      rx <= bits[i];
      wait_clks(CLKS_PER_BIT);
    end
  endtask

  initial
  begin
    rx          = 1'b1;
    frame_cnt   = 0;
    frame_byte  = '0;
    parity_ok   = 1'b0;
    stop_ok     = 1'b0;
    gap_clks    = 0;
    addr_q      = '0;
    expect_data = 1'b0;
    idle_cnt    = 0;
    for (int a = 0; a < 128; a++)
      regs[a] = 8'(a * 37) ^ 8'hc3;
    forever
    begin
      @(posedge clk);
      if (!rst_n || tx !== 1'b0)
        idle_cnt++;
      else
      begin
        receive_frame(rx_byte, rx_par, rx_stop);
        frame_byte <= rx_byte;
        parity_ok  <= (rx_par == ~^rx_byte);
        stop_ok    <= rx_stop;
        gap_clks   <= idle_cnt;
        frame_cnt  <= frame_cnt + 1;
        wait_clks(CLKS_PER_BIT - 1 - CLKS_PER_BIT / 2); // rest of the stop bit
        idle_cnt = 0;
        if (expect_data)
        begin
          regs[addr_q] = rx_byte;
          expect_data  = 1'b0;
        end
        else
        begin
          addr_q      = rx_byte[6:0];
          expect_data = rx_byte[7];
          if (!rx_byte[7] && !silent)
          begin
            wait_clks(reply_delay);
            send_frame(regs[addr_q], corrupt_parity);
          end
        end
      end
    end
  end

endmodule

// ==== test/tb_uart_cmd_bridge.sv ====
`timescale 1ns/1ps

module tb_uart_cmd_bridge;

  localparam int clks_per_bit     = 8;
  localparam int gap_clks         = 20;
  localparam int rsp_timeout_clks = 400;
  localparam int max_cycles       = 40000; // about 30 commands of at most 1200 clocks

  typedef struct packed {
    logic [7:0]  data;
    logic        parity_ok;
    logic        stop_ok;
    logic [31:0] gap;
  } seen_frame_t;

  logic               clk = 1'b0;
  logic               rst_n;
  logic               cmd_req;
  uart_cmd_pkg::cmd_t cmd;
  logic               cmd_ack;
  logic               rsp_req;
  uart_cmd_pkg::rsp_t rsp;
  logic               rsp_ack;
  logic               tx;
  logic               rx;
  logic               corrupt_parity;
  logic               silent;
  int                 reply_delay;
  int                 peer_cnt;
  logic [7:0]         peer_byte;
  logic               peer_parity_ok;
  logic               peer_stop_ok;
  int                 peer_gap;
  int                 seen_cnt   = 0;
  int                 cycle_cnt  = 0;
  int                 rsp_pulses = 0;
  logic               ack_q      = 1'b0;
  logic               req_q      = 1'b0;
  logic               rsp_req_q  = 1'b0;
  seen_frame_t        new_frame;
  seen_frame_t        frames_q [$];
  logic [7:0]         shadow [128]; // last value written per address
  logic [6:0]         written_q [$];

  always #5 clk = ~clk;

  uart_cmd_bridge #(
    .CLKS_PER_BIT     (clks_per_bit),
    .GAP_CLKS         (gap_clks),
    .RSP_TIMEOUT_CLKS (rsp_timeout_clks)
  ) uart_cmd_bridge_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd_req (cmd_req),
    .cmd     (cmd),
    .cmd_ack (cmd_ack),
    .rsp_req (rsp_req),
    .rsp     (rsp),
    .rsp_ack (rsp_ack),
    .tx      (tx),
    .rx      (rx)
  );

  uart_peer_model #(
    .CLKS_PER_BIT (clks_per_bit)
  ) peer_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .tx             (tx),
    .rx             (rx),
    .corrupt_parity (corrupt_parity),
    .silent         (silent),
    .reply_delay    (reply_delay),
    .frame_cnt      (peer_cnt),
    .frame_byte     (peer_byte),
    .parity_ok      (peer_parity_ok),
    .stop_ok        (peer_stop_ok),
    .gap_clks       (peer_gap)
  );

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic report_value(input string test, input logic [31:0] exp, input logic [31:0] act);
    stop_run($sformatf("** Error [%s] expected 0x%0h actual 0x%0h", test, exp, act));
  endtask

  // handshake rules, frame collection and the run limit
  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt > max_cycles)
      stop_run($sformatf("timeout, run went past %0d cycles", max_cycles));
    if (rst_n)
    begin
      assert (!(cmd_ack && !ack_q) || req_q) else stop_run("cmd_ack rose while cmd_req was low");
      assert (!(!cmd_ack && ack_q) || !req_q) else stop_run("cmd_ack fell before cmd_req fell");
      if (rsp_req && !rsp_req_q)
        rsp_pulses++;
    end
    if (peer_cnt != seen_cnt)
    begin
      new_frame = '{data: peer_byte, parity_ok: peer_parity_ok, stop_ok: peer_stop_ok,
                    gap: peer_gap};
      frames_q.push_back(new_frame);
      seen_cnt = peer_cnt;
    end
    ack_q     = cmd_ack;
    req_q     = cmd_req;
    rsp_req_q = rsp_req;
  end

  // one command handshake, answering the response handshake on reads
  task automatic run_cmd(input uart_cmd_pkg::cmd_t c, output uart_cmd_pkg::rsp_t r,
                         output int pulses);
    int pulses_at_start;
    pulses_at_start = rsp_pulses;
    r = '0;
    cmd     <= c;
    cmd_req <= 1'b1;
    @(posedge clk);
    while (!cmd_ack)
    begin
      if (rsp_req && !rsp_ack)
      begin
        r = rsp;
        rsp_ack <= 1'b1;
      end
      else if (!rsp_req && rsp_ack)
        rsp_ack <= 1'b0;
      @(posedge clk);
    end
    pulses = rsp_pulses - pulses_at_start;
    cmd_req <= 1'b0;
    while (cmd_ack)
      @(posedge clk);
  endtask

  task automatic do_write(input logic [6:0] a, input logic [7:0] d);
    uart_cmd_pkg::cmd_t c;
    uart_cmd_pkg::rsp_t r;
    int                 pulses;
    seen_frame_t        hdr;
    seen_frame_t        dat;
    c = '{write: 1'b1, addr: a, data: d};
    run_cmd(c, r, pulses);
    assert (frames_q.size() == 2)
      else stop_run($sformatf("write sent %0d frames instead of 2", frames_q.size()));
    hdr = frames_q.pop_front();
    dat = frames_q.pop_front();
    assert (hdr.data == {1'b1, a}) else report_value("write header", 32'({1'b1, a}), 32'(hdr.data));
    assert (dat.data == d) else report_value("write data", 32'(d), 32'(dat.data));
    assert (hdr.parity_ok && dat.parity_ok) else stop_run("write frame has a wrong parity bit");
    assert (hdr.stop_ok && dat.stop_ok) else stop_run("write frame has a low stop bit");
    assert (dat.gap >= gap_clks) else report_value("write gap minimum", gap_clks, dat.gap);
    assert (pulses == 0) else report_value("write rsp_req pulses", 0, pulses);
    shadow[a] = d;
    written_q.push_back(a);
  endtask

  task automatic do_read(input logic [6:0] a, input logic corrupt, input logic quiet);
    uart_cmd_pkg::cmd_t c;
    uart_cmd_pkg::rsp_t r;
    uart_cmd_pkg::rsp_t exp_r;
    int                 pulses;
    seen_frame_t        hdr;
    string              test_name;
    c = '{write: 1'b0, addr: a, data: 8'h00};
    corrupt_parity <= corrupt;
    silent         <= quiet;
    reply_delay    <= int'($urandom % (rsp_timeout_clks / 2));
    run_cmd(c, r, pulses);
    if (quiet)
    begin
      exp_r     = '{data: 8'h00, parity_err: 1'b0, frame_err: 1'b0, timeout: 1'b1};
      test_name = "read timeout";
    end
    else
    begin
      exp_r     = '{data: shadow[a], parity_err: corrupt, frame_err: 1'b0, timeout: 1'b0};
      test_name = corrupt ? "read parity error" : "read data";
    end
    assert (frames_q.size() == 1)
      else stop_run($sformatf("read sent %0d frames instead of 1", frames_q.size()));
    hdr = frames_q.pop_front();
    assert (hdr.data == {1'b0, a}) else report_value("read header", 32'({1'b0, a}), 32'(hdr.data));
    assert (hdr.parity_ok && hdr.stop_ok) else stop_run("read header frame is malformed");
    assert (pulses == 1) else report_value("read rsp_req pulses", 1, pulses);
    assert (r == exp_r) else report_value(test_name, 32'(exp_r), 32'(r));
  endtask

  initial
  begin
    void'($urandom(32'hfcbf_f1b3));
    rst_n          = 1'b0;
    cmd_req        = 1'b0;
    cmd            = '0;
    rsp_ack        = 1'b0;
    corrupt_parity = 1'b0;
    silent         = 1'b0;
    reply_delay    = 0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    assert (tx === 1'b1 && cmd_ack === 1'b0 && rsp_req === 1'b0)
      else report_value("reset state", 32'b100, 32'({tx, cmd_ack, rsp_req}));
    for (int i = 0; i < 12; i++)
      do_write(7'($urandom), 8'($urandom));
    for (int i = 0; i < 12; i++)
    begin
      if (i % 4 == 3)
        do_write(written_q[$urandom % written_q.size()], 8'($urandom)); // overwrite
      do_read(written_q[$urandom % written_q.size()], i % 6 == 4, i % 6 == 5);
    end
    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== sources.f ====
hw/uart_line_pkg.sv
hw/uart_cmd_pkg.sv
hw/uart_tx_frame.sv
hw/uart_rx_frame.sv
hw/uart_cmd_ctrl.sv
hw/uart_cmd_bridge.sv
test/uart_peer_model.sv
test/tb_uart_cmd_bridge.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module tb_uart_cmd_bridge -f sources.f -o sim_tb > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

grep -q "TEST FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "no pass message in sim.log"; exit 1; }
echo "simulation passed"
